// ==== flist.f ====
source/archie_pkg.sv
source/loader_writer.sv
source/mem_arbiter.sv
source/wb_ram.sv
source/archie_mem_top.sv
sim/tb_archie_mem_top.sv

// ==== Makefile ====
TOP := tb_archie_mem_top
SRCS := $(wildcard source/*.sv sim/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
		-f flist.f --top-module $(TOP)

obj_dir/V$(TOP): flist.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f flist.f --top-module $(TOP) -Mdir obj_dir

sim: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
		echo "$$out"; \
		echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir

// ==== sim/tb_archie_mem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_archie_mem_top;

	import archie_pkg::*;

	localparam int SEED      = 35681;
	localparam int ACK_LIMIT = 20; // cycles a core access may wait for ack
	localparam int STALL_LEN = 10;
	localparam int BYTE_GAP  = 6;  // cycles between host wr pulses

	typedef enum logic [2:0] {
		K_BYTE, K_END, K_STALL, K_WRITE, K_READ, K_BUTTON
	} kind_t;

	// addr holds a byte address for host steps and a word address otherwise
	typedef struct packed {
		kind_t      kind;
		dio_index_t index;
		load_addr_t addr;
		word_t      data;
		sel_t       sel;
		word_t      exp_val;
	} step_t;

	logic    clk_sys;
	logic    rst_n_i;
	ioctl_t  ioctl;
	wb_req_t core_req;
	wb_rsp_t core_rsp;
	logic    button_reset;
	logic    sys_reset;

	step_t steps [$];
	string names [$];
	byte_t rom_bytes [8];
	int    value_errors;
	int    timeouts;
	logic  table_ready;

	archie_mem_top archie_mem_top_inst (
		.clk_sys        (clk_sys),
		.rst_n_i        (rst_n_i),
		.ioctl_i        (ioctl),
		.core_req_i     (core_req),
		.core_rsp_o     (core_rsp),
		.button_reset_i (button_reset),
		.sys_reset_o    (sys_reset)
	);

	initial clk_sys = 1'b0;
	always #5 clk_sys = ~clk_sys;

	function automatic void add_step(kind_t kind, dio_index_t index, load_addr_t addr,
			word_t data, sel_t sel, word_t exp_val, string name);
		step_t s;
		s = '{kind: kind, index: index, addr: addr, data: data, sel: sel, exp_val: exp_val};
		steps.push_back(s);
		names.push_back(name);
	endfunction

	task automatic compare_value(input string name, input word_t expected, input word_t actual);
		if (expected !== actual) begin
			value_errors++;
			$display("error: %s expected %h actual %h", name, expected, actual);
		end
	endtask

	// one wr pulse and idle until the next byte slot
	task automatic host_byte(input dio_index_t index, input load_addr_t addr, input byte_t data);
		@(negedge clk_sys);
		ioctl.download = 1'b1;
		ioctl.index    = index;
		ioctl.addr     = addr;
		ioctl.dout     = data;
		ioctl.wr       = 1'b1;
		@(negedge clk_sys);
		ioctl.wr = 1'b0;
		repeat (BYTE_GAP - 2) @(negedge clk_sys);
	endtask

	task automatic end_download(input word_t exp_val, input string name);
		@(negedge clk_sys);
		ioctl.download = 1'b0;
		repeat (2) @(negedge clk_sys); // readiness follows one cycle after active falls
		compare_value(name, exp_val, word_t'(sys_reset));
	endtask

	task automatic core_access(input logic we, input ram_addr_t adr, input word_t data,
			input sel_t sel, output logic got, output word_t rdata);
		int waited;
		waited = 0;
		got    = 1'b0;
		rdata  = '0;
		@(negedge clk_sys);
		core_req = '{stb: 1'b1, we: we, sel: sel, adr: adr, dat: data};
		while (!got && waited < ACK_LIMIT) begin
			@(negedge clk_sys);
			waited++;
			if (core_rsp.ack) begin
				got   = 1'b1;
				rdata = core_rsp.dat;
			end
		end
		core_req.stb = 1'b0;
		if (!got) begin
			timeouts++;
			$display("core access to word %0d got no ack within %0d cycles", adr, ACK_LIMIT);
		end
	endtask

	// core holds a read during a download and must see no ack
	task automatic stall_check(input word_t exp_val, input string name);
		logic seen_ack;
		seen_ack = 1'b0;
		@(negedge clk_sys);
		core_req = '{stb: 1'b1, we: 1'b0, sel: 4'b1111, adr: '0, dat: '0};
		repeat (STALL_LEN) begin
			@(negedge clk_sys);
			if (core_rsp.ack) seen_ack = 1'b1;
		end
		core_req.stb = 1'b0;
		compare_value(name, exp_val, word_t'(!seen_ack));
	endtask

	task automatic button_check(input word_t exp_val, input string name);
		@(negedge clk_sys);
		button_reset = 1'b1;
		@(negedge clk_sys);
		compare_value({name, " pressed"}, 32'd1, word_t'(sys_reset));
		button_reset = 1'b0;
		@(negedge clk_sys);
		compare_value({name, " released"}, exp_val, word_t'(sys_reset));
	endtask

	initial begin
		step_t s;
		word_t wdat;
		word_t word0;
		word_t word1;
		word_t merged;
		logic  got;
		word_t rdata;

		void'($urandom(SEED));
		rst_n_i      = 1'b0;
		ioctl        = '0;
		core_req     = '0;
		button_reset = 1'b0;
		table_ready  = 1'b0;
		value_errors = 0;
		timeouts     = 0;

		for (int i = 0; i < 8; i++) begin
			rom_bytes[i] = byte_t'($urandom);
		end
		wdat   = word_t'($urandom);
		word0  = {rom_bytes[3], rom_bytes[2], rom_bytes[1], rom_bytes[0]}; // little endian
		word1  = {rom_bytes[7], rom_bytes[6], rom_bytes[5], rom_bytes[4]};
		merged = {rom_bytes[7], wdat[23:16], rom_bytes[5], wdat[7:0]};    // lanes 0 and 2

		// a cmos download first keeps the cpu in reset
		add_step(K_BYTE, 8'd3, 24'd4, 32'h5a, '0, '0, "cmos byte");
		add_step(K_END, 8'd3, '0, '0, '0, 32'd1, "cmos end keeps reset");
		add_step(K_BYTE, ROM_INDEX_OS, 24'd0, word_t'(rom_bytes[0]), '0, '0, "rom byte 0");
		add_step(K_BYTE, ROM_INDEX_OS, 24'd1, word_t'(rom_bytes[1]), '0, '0, "rom byte 1");
		add_step(K_STALL, ROM_INDEX_OS, '0, '0, '0, 32'd1, "core stalled in download");
		for (int i = 2; i < 8; i++) begin
			add_step(K_BYTE, ROM_INDEX_OS, load_addr_t'(i), word_t'(rom_bytes[i]), '0, '0,
				"rom byte");
		end
		add_step(K_END, ROM_INDEX_OS, '0, '0, '0, 32'd0, "rom end releases reset");
		add_step(K_READ, '0, 24'd0, '0, 4'b1111, word0, "readback word 0");
		add_step(K_READ, '0, 24'd1, '0, 4'b1111, word1, "readback word 1");
		add_step(K_WRITE, '0, 24'd1, wdat, 4'b0101, '0, "lane write word 1");
		add_step(K_READ, '0, 24'd1, '0, 4'b1111, merged, "lane write readback");
		// inverted lane bytes so that a stray write always shows up
		add_step(K_BYTE, 8'd3, 24'd4, word_t'(~wdat[7:0]), '0, '0, "cmos byte word 1");
		add_step(K_BYTE, 8'd3, 24'd6, word_t'(~wdat[23:16]), '0, '0, "cmos byte word 1");
		add_step(K_END, 8'd3, '0, '0, '0, 32'd0, "cmos end after load");
		add_step(K_READ, '0, 24'd1, '0, 4'b1111, merged, "word 1 after cmos");
		add_step(K_BUTTON, '0, '0, '0, '0, 32'd0, "button reset");
		table_ready = 1'b1;

		repeat (8) @(posedge clk_sys);
		@(negedge clk_sys);
		rst_n_i = 1'b1;
		@(negedge clk_sys);
		compare_value("reset sys_reset", 32'd1, word_t'(sys_reset));
		compare_value("reset core ack", 32'd0, word_t'(core_rsp.ack));

		for (int i = 0; i < steps.size(); i++) begin
			s = steps[i];
			case (s.kind)
				K_BYTE:   host_byte(s.index, s.addr, byte_t'(s.data));
				K_END:    end_download(s.exp_val, names[i]);
				K_STALL:  stall_check(s.exp_val, names[i]);
				K_WRITE:  core_access(1'b1, ram_addr_t'(s.addr), s.data, s.sel, got, rdata);
				K_READ: begin
					core_access(1'b0, ram_addr_t'(s.addr), '0, s.sel, got, rdata);
					if (got) compare_value(names[i], s.exp_val, rdata);
				end
				default:  button_check(s.exp_val, names[i]);
			endcase
		end

		repeat (4) @(negedge clk_sys);
		$display("value errors %0d, ack timeouts %0d", value_errors, timeouts);
		if (value_errors == 0 && timeouts == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

	// bound grows with the table length
	initial begin
		wait (table_ready);
		repeat (steps.size() * 40 + 200) @(posedge clk_sys);
		$display("watchdog expired before the test table was done");
		$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== source/archie_mem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module archie_mem_top (
	input  wire logic               clk_sys,
	input  wire logic               rst_n_i,
	input  archie_pkg::ioctl_t      ioctl_i,
	input  archie_pkg::wb_req_t     core_req_i,
	output archie_pkg::wb_rsp_t     core_rsp_o,
	input  wire logic               button_reset_i,
	output logic                    sys_reset_o
);

	import archie_pkg::*;

	wb_req_t loader_req;
	wb_req_t ram_req;
	wb_rsp_t ram_rsp;
	logic    loader_active;
	logic    loader_ack;
	logic    rom_ready;

	// host bytes to bus writes
	loader_writer loader_writer_inst (
		.clk_sys         (clk_sys),
		.rst_n_i         (rst_n_i),
		.ioctl_i         (ioctl_i),
		.loader_ack_i    (loader_ack),
		.loader_req_o    (loader_req),
		.loader_active_o (loader_active),
		.rom_ready_o     (rom_ready)
	);

	mem_arbiter mem_arbiter_inst (
		.clk_sys         (clk_sys),
		.loader_active_i (loader_active),
		.loader_req_i    (loader_req),
		.core_req_i      (core_req_i),
		.ram_rsp_i       (ram_rsp),
		.ram_req_o       (ram_req),
		.loader_ack_o    (loader_ack),
		.core_rsp_o      (core_rsp_o)
	);

	// stands in for the SDRAM controller
	wb_ram wb_ram_inst (
		.clk_sys (clk_sys),
		.rst_n_i (rst_n_i),
		.req_i   (ram_req),
		.rsp_o   (ram_rsp)
	);

	// cpu held in reset until a ROM is loaded, or while the button is down
	assign sys_reset_o = !rom_ready || button_reset_i;

endmodule

`default_nettype wire

// ==== source/wb_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_ram (
	input  wire logic               clk_sys,
	input  wire logic               rst_n_i,
	input  archie_pkg::wb_req_t     req_i,
	output archie_pkg::wb_rsp_t     rsp_o
);

	import archie_pkg::*;

	word_t mem [RAM_DEPTH];
	logic  ack_q;
	word_t dat_q;
	logic  accept;

	// a held stb is taken once and skipped in the ack cycle
	assign accept = req_i.stb && !ack_q;

	always_ff @(posedge clk_sys or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= accept;
		end
	end

	// untouched byte lanes keep their contents
	always_ff @(posedge clk_sys) begin
		if (accept && req_i.we) begin
			for (int i = 0; i < LANES; i++) begin
				if (req_i.sel[i]) begin
					mem[req_i.adr][i*8 +: 8] <= req_i.dat[i*8 +: 8];
				end
			end
		end
	end

	// read data lines up with ack
	always_ff @(posedge clk_sys) begin
		if (accept) begin
			dat_q <= mem[req_i.adr]; // old word on a write
		end
	end

	assign rsp_o = '{
		ack: ack_q,
		dat: dat_q
	};

	// any master that writes has to name at least one lane
	a_sel_on_write: assert property (
		@(posedge clk_sys) disable iff (!rst_n_i)
		(req_i.stb && req_i.we) |-> (req_i.sel != '0)
	);

endmodule

`default_nettype wire

// ==== source/mem_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
	input  wire logic               clk_sys,
	input  wire logic               loader_active_i,
	input  archie_pkg::wb_req_t     loader_req_i,
	input  archie_pkg::wb_req_t     core_req_i,
	input  archie_pkg::wb_rsp_t     ram_rsp_i,
	output archie_pkg::wb_req_t     ram_req_o,
	output logic                    loader_ack_o,
	output archie_pkg::wb_rsp_t     core_rsp_o
);

	import archie_pkg::*;

	wb_req_t sel_req;
	logic    core_ack;

	// loader owns the bus for the whole download
	always_comb begin
		if (loader_active_i) begin
			sel_req = loader_req_i;
		end else begin
			sel_req = core_req_i; // core stb is simply not seen while loading
		end
	end

	assign ram_req_o = sel_req;

	// ack steering, core waits with its stb held during a download
	assign loader_ack_o = loader_active_i ? ram_rsp_i.ack : 1'b0;
	assign core_ack     = loader_active_i ? 1'b0 : ram_rsp_i.ack;

	assign core_rsp_o = '{
		ack: core_ack,
		dat: ram_rsp_i.dat   // read data shared, ack qualifies it
	};

	// acks trail their request by one cycle, so an ack right after a
	// download still belongs to the loader and must not reach the core
	a_no_core_ack_in_download: assert property (
		@(posedge clk_sys)
		(loader_active_i || $past(loader_active_i)) |-> !core_rsp_o.ack
	);

endmodule

`default_nettype wire

// ==== source/loader_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

module loader_writer (
	input  wire logic               clk_sys,
	input  wire logic               rst_n_i,
	input  archie_pkg::ioctl_t      ioctl_i,
	input  wire logic               loader_ack_i,
	output archie_pkg::wb_req_t     loader_req_o,
	output logic                    loader_active_o,
	output logic                    rom_ready_o
);

	import archie_pkg::*;

	logic      loader_active;
	logic      loader_active_old;
	logic      stb_q;
	logic      rom_ready_q;
	sel_t      sel_q;
	ram_addr_t adr_q;
	byte_t     byte_q;

	// only the two ROM slots go to memory, CMOS and others are left alone
	assign loader_active = ioctl_i.download &&
		(ioctl_i.index == ROM_INDEX_OS || ioctl_i.index == ROM_INDEX_ALT);

	// strobe raised per host byte, dropped once the memory acks
	always_ff @(posedge clk_sys or negedge rst_n_i) begin
		if (!rst_n_i) begin
			stb_q <= 1'b0;
		end else if (ioctl_i.wr && loader_active) begin
			stb_q <= 1'b1;
		end else if (loader_ack_i) begin
			stb_q <= 1'b0;
		end
	end

	// byte payload captured with the pulse, host may move on afterwards
	always_ff @(posedge clk_sys) begin
		if (ioctl_i.wr && loader_active) begin
			sel_q  <= sel_t'(4'b0001 << ioctl_i.addr[1:0]);
			adr_q  <= ioctl_i.addr[RAM_ADDR_W+1:2];
			byte_q <= ioctl_i.dout;
		end
	end

	// rom is ready after the first ROM download ends
	always_ff @(posedge clk_sys or negedge rst_n_i) begin
		if (!rst_n_i) begin
			loader_active_old <= 1'b0;
			rom_ready_q       <= 1'b0;
		end else begin
			loader_active_old <= loader_active;
			if (loader_active_old && !loader_active) begin
				rom_ready_q <= 1'b1; // sticky until reset
			end
		end
	end

	assign loader_req_o = '{
		stb: stb_q,
		we:  1'b1,            // loader only ever writes
		sel: sel_q,
		adr: adr_q,
		dat: {LANES{byte_q}}  // byte copied to every lane
	};

	assign loader_active_o = loader_active;
	assign rom_ready_o     = rom_ready_q;

	// host bytes must be spaced so that each write completes first
	a_no_wr_while_pending: assert property (
		@(posedge clk_sys) disable iff (!rst_n_i)
		(ioctl_i.wr && loader_active) |-> !stb_q
	);

endmodule

`default_nettype wire

// ==== source/archie_pkg.sv ====
`default_nettype none

package archie_pkg;

	// plain data widths
	typedef logic [7:0]  byte_t;
	typedef logic [31:0] word_t;
	typedef logic [3:0]  sel_t;       // one bit per byte lane
	typedef logic [23:0] load_addr_t; // host byte address
	typedef logic [7:0]  dio_index_t; // host download slot

	// on-chip word memory in place of the SDRAM
	localparam int RAM_ADDR_W = 10;
	localparam int RAM_DEPTH  = 1 << RAM_ADDR_W;
	localparam int LANES      = 4;

	typedef logic [RAM_ADDR_W-1:0] ram_addr_t;

	// download slots that carry a ROM image
	localparam dio_index_t ROM_INDEX_OS  = 8'd1;
	localparam dio_index_t ROM_INDEX_ALT = 8'd2;

	// bus request, held while stb is high
	typedef struct packed {
		logic      stb;
		logic      we;
		sel_t      sel;
		ram_addr_t adr; // word address
		word_t     dat;
	} wb_req_t;

	// bus response, ack is a single cycle
	typedef struct packed {
		logic  ack;
		word_t dat;
	} wb_rsp_t;

	// host download port, wr pulses once per byte
	typedef struct packed {
		logic       download;
		dio_index_t index;
		logic       wr;
		load_addr_t addr;
		byte_t      dout;
	} ioctl_t;

endpackage

`default_nettype wire
